/* vlog.f */
design/dz_pkg.sv
design/tick_gen.sv
design/phase_ctrl.sv
design/dz_show.sv
design/crossing_top.sv
sim/crossing_assertions.sv
sim/crossing_checker.sv
sim/crossing_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module crossing_tb -f vlog.f -o crossing_sim
	./obj_dir/crossing_sim +verilator+error+limit+1000 | tee sim.log
	@grep -q "^>>> PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/crossing_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module crossing_tb import dz_pkg::*; ();

    localparam int unsigned sec_div     = 40;
    localparam int unsigned red_secs    = 3;
    localparam int unsigned green_secs  = 5;
    localparam int unsigned yellow_secs = 2;

    typedef struct packed {
        logic       hold;
        logic [3:0] secs;
        phase_t     phase;
        logic [2:0] digit;
    } step_t;

    // hold, seconds to run, then the phase and digit expected
    localparam int n_steps = 10;
    localparam step_t steps [n_steps] = '{
        '{1'b0, 4'd0, ph_red,    3'd3},
        '{1'b0, 4'd2, ph_red,    3'd1},
        '{1'b0, 4'd2, ph_green,  3'd5},
        '{1'b1, 4'd3, ph_green,  3'd5},    // frozen
        '{1'b0, 4'd3, ph_green,  3'd2},
        '{1'b0, 4'd3, ph_yellow, 3'd2},
        '{1'b1, 4'd2, ph_yellow, 3'd2},
        '{1'b0, 4'd3, ph_red,    3'd3},
        '{1'b0, 4'd4, ph_green,  3'd5},
        '{1'b0, 4'd6, ph_yellow, 3'd2}
    };

    logic        clk;
    logic        rst;
    logic        hold;
    lamp_t       lamps;
    matrix_t     matrix;
    int unsigned chk_errors;
    int unsigned sva_fails;
    int unsigned timeouts;

    crossing_top #(
        .SCAN_DIV    (3),
        .SEC_DIV     (sec_div),
        .RED_SECS    (red_secs),
        .GREEN_SECS  (green_secs),
        .YELLOW_SECS (yellow_secs)
    ) i_crossing_top (.*);

    crossing_checker #(
        .RED_SECS    (red_secs),
        .GREEN_SECS  (green_secs),
        .YELLOW_SECS (yellow_secs)
    ) i_checker (
        .*,
        .sec_tick  (i_crossing_top.sec_tick),
        .scan_tick (i_crossing_top.scan_tick),
        .errors    (chk_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic wait_second();
        int unsigned n;
        n = 0;
        @(negedge clk);
        while (!i_crossing_top.sec_tick && n < 2 * sec_div)
        begin
            @(negedge clk);
            n++;
        end
        if (!i_crossing_top.sec_tick)
        begin
            timeouts++;
            $display("The one-second strobe did not come within %0d clocks", 2 * sec_div);
        end
    endtask

    // well under one second, so a skipped digit cannot match
    task automatic wait_state(input step_t s);
        int unsigned n;
        n = 0;
        @(negedge clk);
        while (i_crossing_top.disp !== {s.phase, s.digit} && n < sec_div / 2)
        begin
            @(negedge clk);
            n++;
        end
        if (i_crossing_top.disp !== {s.phase, s.digit})
        begin
            timeouts++;
            $display("The light never reached phase %0d with digit %0d", s.phase, s.digit);
        end
    endtask

    initial
    begin
        rst = 1'b1;
        hold = 1'b0;
        timeouts = 0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_steps; i++)
        begin
            hold = steps[i].hold;
            repeat (steps[i].secs) wait_second();
            wait_state(steps[i]);
        end
        @(negedge clk);
        sva_fails = i_crossing_top.i_dz_show.i_show_sva.fails
                  + i_crossing_top.i_phase_ctrl.i_ctrl_sva.fails;
        $display("checker errors %0d, assertion failures %0d, timeouts %0d",
                 chk_errors, sva_fails, timeouts);
        if (chk_errors == 0 && sva_fails == 0 && timeouts == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/crossing_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module crossing_checker import dz_pkg::*; #(
    parameter int unsigned RED_SECS    = 3,
    parameter int unsigned GREEN_SECS  = 5,
    parameter int unsigned YELLOW_SECS = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        hold,
    input  logic        sec_tick,
    input  logic        scan_tick,
    input  lamp_t       lamps,
    input  matrix_t     matrix,
    output int unsigned errors
);

    phase_t      m_phase;
    logic [2:0]  m_digit;
    logic [2:0]  m_row;
    logic        m_run;
    matrix_t     m_matrix;
    lamp_t       m_lamps;
    int unsigned err_cnt = 0;

    assign m_lamps = '{m_phase == ph_red, m_phase == ph_yellow, m_phase == ph_green};
    assign errors  = err_cnt;

    function automatic matrix_t draw(input phase_t ph, input logic [2:0] dig,
                                     input logic [2:0] r, input logic lit);
        matrix_t    m;
        logic [7:0] pat;
        pat    = glyph_font[dig][r];
        m.row  = lit ? ~(8'h01 << r) : 8'hff;
        m.colr = (ph == ph_red || ph == ph_yellow) ? pat : 8'h00;
        m.colg = (ph == ph_green || ph == ph_yellow) ? pat : 8'h00;
        return m;
    endfunction

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            m_phase  <= ph_red;
            m_digit  <= 3'(RED_SECS);
            m_row    <= 3'd0;
            m_run    <= 1'b0;
            m_matrix <= '{8'hff, 8'h00, 8'h00};
        end
        else
        begin
            m_matrix <= draw(m_phase, m_digit, m_row, m_run);    // one clock behind
            if (scan_tick)
            begin
                m_row <= m_row + 3'd1;
                m_run <= 1'b1;
            end
            if (sec_tick && !hold && m_digit != 3'd0)
                m_digit <= m_digit - 3'd1;
            else if (sec_tick && !hold)
            begin
                // zero passed, next phase at full length
                m_phase <= (m_phase == ph_red) ? ph_green :
                           (m_phase == ph_green) ? ph_yellow : ph_red;
                m_digit <= (m_phase == ph_red) ? 3'(GREEN_SECS) :
                           (m_phase == ph_green) ? 3'(YELLOW_SECS) : 3'(RED_SECS);
            end
        end
    end

    always @(negedge clk)
    begin
        if (!rst && lamps !== m_lamps)
        begin
            err_cnt++;
            $display("Fail lamps: got %h expected %h", lamps, m_lamps);
        end
        if (!rst && matrix !== m_matrix)
        begin
            err_cnt++;
            $display("Fail matrix: got %h expected %h", matrix, m_matrix);
        end
    end

endmodule

`default_nettype wire

/* sim/crossing_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module crossing_assertions import dz_pkg::*; #(
    parameter bit SCAN_SIDE = 1'b1    // high when bound to dz_show
) (
    input logic       clk,
    input logic       rst,
    input logic       scan_tick,
    input logic [2:0] row_cnt,
    input logic [7:0] row,
    input logic [2:0] lamps,
    input logic [2:0] digit
);

    int unsigned row_fails = 0;
    int unsigned lamp_fails = 0;
    int unsigned digit_fails = 0;
    int unsigned scan_fails = 0;
    int unsigned fails;

    assign fails = row_fails + lamp_fails + digit_fails + scan_fails;

    if (SCAN_SIDE)
    begin : g_scan
        row_legal: assert property (@(posedge clk) disable iff (rst)
            row == 8'hff || $onehot(~row))
        else
        begin
            $error("more than one matrix row pulled low");
            row_fails++;
        end

        // row counter steps only on a scan strobe
        row_step: assert property (@(posedge clk) disable iff (rst)
            row_cnt != $past(row_cnt) |-> $past(scan_tick))
        else
        begin
            $error("row counter moved without a scan strobe");
            scan_fails++;
        end
    end
    else
    begin : g_ctrl
        lamp_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(lamps))
        else
        begin
            $error("lamps not one-hot");
            lamp_fails++;
        end

        digit_range: assert property (@(posedge clk) disable iff (rst)
            digit <= 3'(max_digit))
        else
        begin
            $error("digit above the largest glyph");
            digit_fails++;
        end
    end

endmodule

bind dz_show crossing_assertions #(
    .SCAN_SIDE (1'b1)
) i_show_sva (
    .clk       (clk),
    .rst       (rst),
    .scan_tick (scan_tick),
    .row_cnt   (row_cnt),
    .row       (matrix.row),
    .lamps     (3'b100),    // no lamps here
    .digit     (disp.digit)
);

bind phase_ctrl crossing_assertions #(
    .SCAN_SIDE (1'b0)
) i_ctrl_sva (
    .clk       (clk),
    .rst       (rst),
    .scan_tick (1'b0),
    .row_cnt   (3'd0),
    .row       (8'hff),
    .lamps     (lamps),
    .digit     (disp.digit)
);

`default_nettype wire

/* design/crossing_top.sv */
`timescale 1ns/1ns
`default_nettype none

module crossing_top import dz_pkg::*; #(
    parameter int unsigned SCAN_DIV    = 1000,
    parameter int unsigned SEC_DIV     = 1000000,
    parameter int unsigned RED_SECS    = 5,
    parameter int unsigned GREEN_SECS  = 5,
    parameter int unsigned YELLOW_SECS = 2
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    hold,
    output lamp_t   lamps,
    output matrix_t matrix
);

    logic  scan_tick;
    logic  sec_tick;
    disp_t disp;

    tick_gen #(
        .SCAN_DIV (SCAN_DIV),
        .SEC_DIV  (SEC_DIV)
    ) i_tick_gen (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .sec_tick  (sec_tick)
    );

    phase_ctrl #(
        .RED_SECS    (RED_SECS),
        .GREEN_SECS  (GREEN_SECS),
        .YELLOW_SECS (YELLOW_SECS)
    ) i_phase_ctrl (
        .clk      (clk),
        .rst      (rst),
        .sec_tick (sec_tick),
        .hold     (hold),
        .lamps    (lamps),
        .disp     (disp)
    );

    dz_show i_dz_show (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .disp      (disp),
        .matrix    (matrix)
    );

endmodule

`default_nettype wire

/* design/dz_show.sv */
`timescale 1ns/1ns
`default_nettype none

module dz_show import dz_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    scan_tick,
    input  disp_t   disp,
    output matrix_t matrix
);

    logic [2:0] row_cnt;
    logic       run;        // set by the first scan strobe
    logic [7:0] glyph;
    logic       use_r;
    logic       use_g;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_cnt <= 3'd0;
            run     <= 1'b0;
        end
        else if (scan_tick)
        begin
            row_cnt <= row_cnt + 3'd1;    // 7 wraps to 0
            run     <= 1'b1;
        end
    end

    // digits past the font draw nothing
    always_comb
    begin
        if (disp.digit > 3'(max_digit))
            glyph = 8'h00;
        else
            glyph = glyph_font[disp.digit][row_cnt];
    end

    // yellow lights both column sets
    always_comb
    begin
        case (disp.phase)
            ph_red:
            begin
                use_r = 1'b1;
                use_g = 1'b0;
            end
            ph_green:
            begin
                use_r = 1'b0;
                use_g = 1'b1;
            end
            ph_yellow:
            begin
                use_r = 1'b1;
                use_g = 1'b1;
            end
            default:
            begin
                use_r = 1'b0;
                use_g = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            matrix.row  <= 8'hff;
            matrix.colr <= 8'h00;
            matrix.colg <= 8'h00;
        end
        else
        begin
            if (run)
                matrix.row <= ~(8'h01 << row_cnt);    // one row pulled low
            else
                matrix.row <= 8'hff;
            matrix.colr <= use_r ? glyph : 8'h00;
            matrix.colg <= use_g ? glyph : 8'h00;
        end
    end

endmodule

`default_nettype wire

/* design/phase_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module phase_ctrl import dz_pkg::*; #(
    parameter int unsigned RED_SECS    = 5,
    parameter int unsigned GREEN_SECS  = 5,
    parameter int unsigned YELLOW_SECS = 2
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  sec_tick,
    input  logic  hold,
    output lamp_t lamps,
    output disp_t disp
);

    disp_t state;

    function automatic phase_t next_phase(input phase_t ph);
        phase_t nxt;
        case (ph)
            ph_red:    nxt = ph_green;
            ph_green:  nxt = ph_yellow;
            default:   nxt = ph_red;      // yellow and the unused code
        endcase
        return nxt;
    endfunction

    function automatic logic [2:0] phase_len(input phase_t ph);
        logic [2:0] len;
        case (ph)
            ph_green:  len = 3'(GREEN_SECS);
            ph_yellow: len = 3'(YELLOW_SECS);
            default:   len = 3'(RED_SECS);
        endcase
        return len;
    endfunction

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state.phase <= ph_red;
            state.digit <= 3'(RED_SECS);
        end
        else if (sec_tick && !hold)
        begin
            if (state.digit == 3'd0)
            begin
                // count passed zero, move on and load the new length
                state.phase <= next_phase(state.phase);
                state.digit <= phase_len(next_phase(state.phase));
            end
            else
            begin
                state.digit <= state.digit - 3'd1;
            end
        end
    end

    // exactly one lamp lit
    always_comb
    begin
        lamps = '0;
        case (state.phase)
            ph_green:  lamps.green  = 1'b1;
            ph_yellow: lamps.yellow = 1'b1;
            default:   lamps.red    = 1'b1;
        endcase
    end

    assign disp = state;

endmodule

`default_nettype wire

/* design/tick_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tick_gen #(
    parameter int unsigned SCAN_DIV = 1000,
    parameter int unsigned SEC_DIV  = 1000000
) (
    input  logic clk,
    input  logic rst,
    output logic scan_tick,
    output logic sec_tick
);

    localparam int unsigned div_max = (SCAN_DIV > SEC_DIV) ? SCAN_DIV : SEC_DIV;
    localparam int unsigned cnt_w   = $clog2(div_max + 1);
    localparam int unsigned div_tab [2] = '{SCAN_DIV, SEC_DIV};

    // one down counter per strobe
    for (genvar i = 0; i < 2; i++)
    begin : g_div
        logic [cnt_w-1:0] cnt;
        logic             pulse;

        always_ff @(posedge clk or posedge rst)
        begin
            if (rst)
            begin
                cnt   <= cnt_w'(div_tab[i] - 1);
                pulse <= 1'b0;
            end
            else if (cnt == '0)
            begin
                cnt   <= cnt_w'(div_tab[i] - 1);    // reload
                pulse <= 1'b1;
            end
            else
            begin
                cnt   <= cnt - 1'b1;
                pulse <= 1'b0;
            end
        end
    end

    assign scan_tick = g_div[0].pulse;
    assign sec_tick  = g_div[1].pulse;

endmodule

`default_nettype wire

/* design/dz_pkg.sv */
`default_nettype none

package dz_pkg;

    // cycle order red -> green -> yellow
    typedef enum logic [1:0] {
        ph_red    = 2'd0,
        ph_green  = 2'd1,
        ph_yellow = 2'd2
    } phase_t;

    typedef struct packed {
        logic red;
        logic yellow;
        logic green;
    } lamp_t;

    typedef struct packed {
        phase_t     phase;
        logic [2:0] digit;
    } disp_t;

    // row is active low, columns active high
    typedef struct packed {
        logic [7:0] row;
        logic [7:0] colr;
        logic [7:0] colg;
    } matrix_t;

    localparam int unsigned max_digit = 5;

    // [digit][row] column pattern with msb as the leftmost column
    localparam logic [7:0] glyph_font [6][8] = '{
        '{8'h00, 8'h3c, 8'h42, 8'h42, 8'h42, 8'h42, 8'h42, 8'h3c},    // 0
        '{8'h00, 8'h18, 8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h7e},    // 1
        '{8'h00, 8'h3c, 8'h66, 8'h06, 8'h0c, 8'h30, 8'h60, 8'h7e},    // 2
        '{8'h00, 8'h3c, 8'h66, 8'h06, 8'h1c, 8'h06, 8'h66, 8'h3c},    // 3
        '{8'h00, 8'h0c, 8'h1c, 8'h2c, 8'h4c, 8'h7e, 8'h0c, 8'h0c},    // 4
        '{8'h7e, 8'h60, 8'h7c, 8'h06, 8'h06, 8'h66, 8'h3c, 8'h00}     // 5 sits one row higher
    };

endpackage

`default_nettype wire
